// ==== addrgen_pkg.sv ====
`default_nettype none

package addrgen_pkg;

   // memory address and iteration count width
   localparam int mem_addr_w = 10;

   // period, duty and delay width
   localparam int period_w = 8;

   // generator FSM
   typedef enum logic {
      idle = 1'b0,
      run  = 1'b1
   } gen_state_t;

endpackage

`default_nettype wire

// ==== mem_unit_pkg.sv ====
`default_nettype none

package mem_unit_pkg;

   localparam int data_w = 32; // memory word

   // configuration field opcodes, as written by the host on cfg_field
   typedef enum logic [2:0] {
      f_iterations = 3'd0,
      f_period     = 3'd1,
      f_duty       = 3'd2,
      f_delay      = 3'd3,
      f_start      = 3'd4,
      f_shift      = 3'd5,
      f_incr       = 3'd6
   } cfg_field_t;

   // cfg_sel values and gen_mask bit positions
   localparam logic gen_a = 1'b0; // read generator
   localparam logic gen_b = 1'b1; // write generator

endpackage

`default_nettype wire

// ==== addrgen.sv ====
`default_nettype none

module addrgen #(
   parameter int ADDR_W = addrgen_pkg::mem_addr_w,
   parameter int PER_W  = addrgen_pkg::period_w
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     init,
   input  logic                     run,
   input  logic                     pause,
   input  logic [ADDR_W-1:0]        iterations,
   input  logic [PER_W-1:0]         period,
   input  logic [PER_W-1:0]         duty,
   input  logic [PER_W-1:0]         delay,
   input  logic [ADDR_W-1:0]        start,
   input  logic signed [ADDR_W-1:0] shift,
   input  logic signed [ADDR_W-1:0] incr,
   output logic [ADDR_W-1:0]        addr,
   output logic                     mem_en,
   output logic                     done
);

   addrgen_pkg::gen_state_t state, state_nxt;

   logic signed [PER_W:0] per_cnt, per_cnt_nxt; // below 1 while delaying
   logic [ADDR_W-1:0]     iter, iter_nxt;
   logic [ADDR_W-1:0]     addr_nxt;
   logic                  mem_en_nxt;
   logic                  done_nxt;
   logic                  rerun, rerun_nxt;   // restarted in last cycle
   logic                  per_end;
   logic                  duty_end;
   logic                  last_iter;

   assign per_end   = per_cnt == $signed({1'b0, period});
   assign duty_end  = per_cnt == $signed({1'b0, duty});
   assign last_iter = iter == iterations;

   always_comb begin
      state_nxt   = state;
      per_cnt_nxt = per_cnt;
      iter_nxt    = iter;
      addr_nxt    = addr;
      mem_en_nxt  = mem_en;
      done_nxt    = done;
      rerun_nxt   = rerun;

      if (state == addrgen_pkg::idle) begin
         if (init) begin
            per_cnt_nxt = (PER_W+1)'(1) - $signed({1'b0, delay});
            addr_nxt    = start;
            iter_nxt    = ADDR_W'(1);
         end
         if (run) begin
            state_nxt = addrgen_pkg::run;
            done_nxt  = 1'b0;
            rerun_nxt = 1'b0;
            if (delay == '0)
               mem_en_nxt = 1'b1; // no delay, enable on next edge
         end
      end else begin
         if (rerun) begin
            done_nxt  = 1'b0; // done lasts one cycle on a rerun
            rerun_nxt = 1'b0;
         end

         // duty window opens after the delay and at each new period
         if (per_cnt == '0 || (per_end && !last_iter))
            mem_en_nxt = 1'b1;
         if (duty_end && (period != duty || last_iter))
            mem_en_nxt = 1'b0;

         per_cnt_nxt = per_cnt + (PER_W+1)'(1);
         if (per_end) begin
            per_cnt_nxt = (PER_W+1)'(1);
            iter_nxt    = iter + ADDR_W'(1);
         end

         if (mem_en)
            addr_nxt = addr + incr;
         if (per_end)
            addr_nxt = addr + incr + shift;
         if (mem_en && duty_end && period != duty)
            addr_nxt = addr; // hold through the idle part of the period

         if (last_iter && per_end) begin
            done_nxt = 1'b1;
            if (run) begin
               addr_nxt   = start;
               iter_nxt   = ADDR_W'(1);
               mem_en_nxt = 1'b1;
               rerun_nxt  = 1'b1;
            end else begin
               state_nxt = addrgen_pkg::idle;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= addrgen_pkg::idle;
         per_cnt <= '0;
         iter    <= '0;
         addr    <= '0;
         mem_en  <= 1'b0;
         done    <= 1'b1;
         rerun   <= 1'b0;
      end else if (!pause) begin
         state   <= state_nxt;
         per_cnt <= per_cnt_nxt;
         iter    <= iter_nxt;
         addr    <= addr_nxt;
         mem_en  <= mem_en_nxt;
         done    <= done_nxt;
         rerun   <= rerun_nxt;
      end
   end

endmodule

`default_nettype wire

// ==== cfg_regs.sv ====
`default_nettype none

module cfg_regs #(
   parameter int ADDR_W = addrgen_pkg::mem_addr_w,
   parameter int PER_W  = addrgen_pkg::period_w
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     cfg_we,
   input  logic                     cfg_sel,
   input  mem_unit_pkg::cfg_field_t cfg_field,
   input  logic [ADDR_W-1:0]        cfg_data,
   input  logic                     init,
   input  logic                     run,
   input  logic [1:0]               gen_mask,
   output logic [ADDR_W-1:0]        iterations_a,
   output logic [PER_W-1:0]         period_a,
   output logic [PER_W-1:0]         duty_a,
   output logic [PER_W-1:0]         delay_a,
   output logic [ADDR_W-1:0]        start_a,
   output logic signed [ADDR_W-1:0] shift_a,
   output logic signed [ADDR_W-1:0] incr_a,
   output logic [ADDR_W-1:0]        iterations_b,
   output logic [PER_W-1:0]         period_b,
   output logic [PER_W-1:0]         duty_b,
   output logic [PER_W-1:0]         delay_b,
   output logic [ADDR_W-1:0]        start_b,
   output logic signed [ADDR_W-1:0] shift_b,
   output logic signed [ADDR_W-1:0] incr_b,
   output logic                     init_a,
   output logic                     run_a,
   output logic                     init_b,
   output logic                     run_b
);

   // one entry per generator, indexed by cfg_sel
   logic [ADDR_W-1:0]        iterations_r [2];
   logic [PER_W-1:0]         period_r     [2];
   logic [PER_W-1:0]         duty_r       [2];
   logic [PER_W-1:0]         delay_r      [2];
   logic [ADDR_W-1:0]        start_r      [2];
   logic signed [ADDR_W-1:0] shift_r      [2];
   logic signed [ADDR_W-1:0] incr_r       [2];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 2; i++) begin
            iterations_r[i] <= '0;
            period_r[i]     <= PER_W'(1); // never a zero period
            duty_r[i]       <= PER_W'(1);
            delay_r[i]      <= '0;
            start_r[i]      <= '0;
            shift_r[i]      <= '0;
            incr_r[i]       <= '0;
         end
      end else if (cfg_we) begin
         case (cfg_field)
            mem_unit_pkg::f_iterations: iterations_r[cfg_sel] <= cfg_data;
            mem_unit_pkg::f_period:     period_r[cfg_sel]     <= cfg_data[PER_W-1:0];
            mem_unit_pkg::f_duty:       duty_r[cfg_sel]       <= cfg_data[PER_W-1:0];
            mem_unit_pkg::f_delay:      delay_r[cfg_sel]      <= cfg_data[PER_W-1:0];
            mem_unit_pkg::f_start:      start_r[cfg_sel]      <= cfg_data;
            mem_unit_pkg::f_shift:      shift_r[cfg_sel]      <= $signed(cfg_data);
            mem_unit_pkg::f_incr:       incr_r[cfg_sel]       <= $signed(cfg_data);
            default: ;
         endcase
      end
   end

   assign iterations_a = iterations_r[mem_unit_pkg::gen_a];
   assign period_a     = period_r[mem_unit_pkg::gen_a];
   assign duty_a       = duty_r[mem_unit_pkg::gen_a];
   assign delay_a      = delay_r[mem_unit_pkg::gen_a];
   assign start_a      = start_r[mem_unit_pkg::gen_a];
   assign shift_a      = shift_r[mem_unit_pkg::gen_a];
   assign incr_a       = incr_r[mem_unit_pkg::gen_a];

   assign iterations_b = iterations_r[mem_unit_pkg::gen_b];
   assign period_b     = period_r[mem_unit_pkg::gen_b];
   assign duty_b       = duty_r[mem_unit_pkg::gen_b];
   assign delay_b      = delay_r[mem_unit_pkg::gen_b];
   assign start_b      = start_r[mem_unit_pkg::gen_b];
   assign shift_b      = shift_r[mem_unit_pkg::gen_b];
   assign incr_b       = incr_r[mem_unit_pkg::gen_b];

   // pulses pass straight through, no added latency
   assign init_a = init & gen_mask[mem_unit_pkg::gen_a];
   assign run_a  = run  & gen_mask[mem_unit_pkg::gen_a];
   assign init_b = init & gen_mask[mem_unit_pkg::gen_b];
   assign run_b  = run  & gen_mask[mem_unit_pkg::gen_b];

endmodule

`default_nettype wire

// ==== dp_mem.sv ====
`default_nettype none

module dp_mem #(
   parameter int ADDR_W = addrgen_pkg::mem_addr_w,
   parameter int DATA_W = mem_unit_pkg::data_w
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              pause,
   input  logic [ADDR_W-1:0] addr_a,
   input  logic              en_a,
   input  logic [ADDR_W-1:0] addr_b,
   input  logic              en_b,
   input  logic [DATA_W-1:0] wr_data,
   output logic [DATA_W-1:0] rd_data,
   output logic              rd_valid
);

   logic [DATA_W-1:0] mem [2**ADDR_W];
   logic              valid_q;

   // port b write, port a registered read (old data on a collision)
   always_ff @(posedge clk) begin
      if (en_b && !pause)
         mem[addr_b] <= wr_data;
      if (en_a && !pause)
         rd_data <= mem[addr_a];
   end

   always_ff @(posedge clk) begin
      if (rst)
         valid_q <= 1'b0;
      else if (!pause)
         valid_q <= en_a;
   end

   // a word held across a pause shows once pause drops
   assign rd_valid = valid_q & ~pause;

endmodule

`default_nettype wire

// ==== mem_unit_top.sv ====
`default_nettype none

module mem_unit_top #(
   parameter int ADDR_W = addrgen_pkg::mem_addr_w,
   parameter int PER_W  = addrgen_pkg::period_w,
   parameter int DATA_W = mem_unit_pkg::data_w
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     cfg_we,
   input  logic                     cfg_sel,
   input  mem_unit_pkg::cfg_field_t cfg_field,
   input  logic [ADDR_W-1:0]        cfg_data,
   input  logic                     init,
   input  logic                     run,
   input  logic [1:0]               gen_mask,
   input  logic                     pause,
   input  logic [DATA_W-1:0]        wr_data,
   output logic [DATA_W-1:0]        rd_data,
   output logic                     rd_valid,
   output logic                     en_b,
   output logic                     done_a,
   output logic                     done_b
);

   logic [ADDR_W-1:0]        iterations_a, iterations_b;
   logic [PER_W-1:0]         period_a, period_b;
   logic [PER_W-1:0]         duty_a, duty_b;
   logic [PER_W-1:0]         delay_a, delay_b;
   logic [ADDR_W-1:0]        start_a, start_b;
   logic signed [ADDR_W-1:0] shift_a, shift_b;
   logic signed [ADDR_W-1:0] incr_a, incr_b;
   logic                     init_a, run_a, init_b, run_b;
   logic [ADDR_W-1:0]        addr_a, addr_b;
   logic                     en_a;

   cfg_regs #(.ADDR_W(ADDR_W), .PER_W(PER_W)) cfg (
      .clk, .rst, .cfg_we, .cfg_sel, .cfg_field, .cfg_data, .init, .run, .gen_mask,
      .iterations_a, .period_a, .duty_a, .delay_a, .start_a, .shift_a, .incr_a,
      .iterations_b, .period_b, .duty_b, .delay_b, .start_b, .shift_b, .incr_b,
      .init_a, .run_a, .init_b, .run_b
   );

   // read side
   addrgen #(.ADDR_W(ADDR_W), .PER_W(PER_W)) gen_rd (
      .clk, .rst, .init(init_a), .run(run_a), .pause,
      .iterations(iterations_a), .period(period_a), .duty(duty_a), .delay(delay_a),
      .start(start_a), .shift(shift_a), .incr(incr_a),
      .addr(addr_a), .mem_en(en_a), .done(done_a)
   );

   // write side, en_b tells the host when to present a word
   addrgen #(.ADDR_W(ADDR_W), .PER_W(PER_W)) gen_wr (
      .clk, .rst, .init(init_b), .run(run_b), .pause,
      .iterations(iterations_b), .period(period_b), .duty(duty_b), .delay(delay_b),
      .start(start_b), .shift(shift_b), .incr(incr_b),
      .addr(addr_b), .mem_en(en_b), .done(done_b)
   );

   dp_mem #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem (
      .clk, .rst, .pause,
      .addr_a, .en_a, .addr_b, .en_b, .wr_data,
      .rd_data, .rd_valid
   );

endmodule

`default_nettype wire

// ==== tb_mem_unit.sv ====
`default_nettype none

module tb_mem_unit;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int addr_w    = addrgen_pkg::mem_addr_w;
   localparam int data_w    = mem_unit_pkg::data_w;
   localparam int addr_mask = (1 << addr_w) - 1;

   logic                     clk = 1'b0;
   logic                     rst;
   logic                     cfg_we;
   logic                     cfg_sel;
   mem_unit_pkg::cfg_field_t cfg_field;
   logic [addr_w-1:0]        cfg_data;
   logic                     init;
   logic                     run;
   logic [1:0]               gen_mask;
   logic                     pause;
   logic [data_w-1:0]        wr_data;
   logic [data_w-1:0]        rd_data;
   logic                     rd_valid;
   logic                     en_b;
   logic                     done_a;
   logic                     done_b;

   integer seed = 32'hfa89;
   int     errors = 0;
   int     tests_run = 0;
   int     tests_failed = 0;
   int     errs_at_start;
   int     first_en_edges;
   int     longest_streak;

   logic [data_w-1:0] wr_words  [$]; // stream fed to port b
   logic [data_w-1:0] exp_words [$];
   logic [data_w-1:0] got       [$]; // words seen with rd_valid
   logic [data_w-1:0] ref_words [$];

   mem_unit_top #(
      .ADDR_W(addr_w),
      .PER_W(addrgen_pkg::period_w),
      .DATA_W(data_w)
   ) UUT (
      .clk, .rst, .cfg_we, .cfg_sel, .cfg_field, .cfg_data, .init, .run, .gen_mask,
      .pause, .wr_data, .rd_data, .rd_valid, .en_b, .done_a, .done_b
   );

   always #50 clk = ~clk;

   pause_masks_valid: assert property (@(posedge clk) disable iff (rst) pause |-> !rd_valid)
      else begin
         errors++;
         $display("[FAIL] rd_valid expected 0x0 got 0x%h during pause", rd_valid);
      end

   // write generator never restarts here, so done and enable exclude each other
   done_b_idle: assert property (@(posedge clk) disable iff (rst) done_b |-> !en_b)
      else begin
         errors++;
         $display("[FAIL] en_b expected 0x0 got 0x%h while done_b", en_b);
      end

   task automatic finish_run();
      $display("tests %0d, passed %0d, failed %0d, check errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   endtask

   task automatic timed_out(input string what);
      errors++;
      $display("timeout: %s", what);
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
         else begin
            errors++;
            $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
         end
   endtask

   task automatic begin_test();
      errs_at_start = errors;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == errs_at_start) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed", tests_run, name);
      end
   endtask

   task automatic write_field(input logic sel, input mem_unit_pkg::cfg_field_t field,
                              input int value);
      @(negedge clk);
      cfg_we    = 1'b1;
      cfg_sel   = sel;
      cfg_field = field;
      cfg_data  = addr_w'(value);
      @(negedge clk);
      cfg_we    = 1'b0;
   endtask

   task automatic config_gen(input logic sel, input int iters, input int period, input int duty,
                             input int delay, input int start, input int shift, input int incr);
      write_field(sel, mem_unit_pkg::f_iterations, iters);
      write_field(sel, mem_unit_pkg::f_period, period);
      write_field(sel, mem_unit_pkg::f_duty, duty);
      write_field(sel, mem_unit_pkg::f_delay, delay);
      write_field(sel, mem_unit_pkg::f_start, start);
      write_field(sel, mem_unit_pkg::f_shift, shift);
      write_field(sel, mem_unit_pkg::f_incr, incr);
   endtask

   // init and run together, held over one rising edge
   task automatic start_gen(input logic sel);
      @(negedge clk);
      init          = 1'b1;
      run           = 1'b1;
      gen_mask      = 2'b00;
      gen_mask[sel] = 1'b1;
      @(negedge clk);
      init     = 1'b0;
      run      = 1'b0;
      gen_mask = 2'b00;
   endtask

   // affine pattern: duty steps of incr, next period from base + shift + duty * incr
   task automatic build_expected(input int start, input int incr, input int shift,
                                 input int duty, input int iters);
      int base;
      base = start;
      for (int i = 0; i < iters; i++) begin
         for (int j = 0; j < duty; j++)
            exp_words.push_back((base + j * incr) & addr_mask); // words hold their address
         base = base + shift + duty * incr;
      end
   endtask

   task automatic write_stream(input int limit);
      int idx;
      int edges;
      idx = 0;
      edges = 1; // start_gen already passed the edge that takes run
      first_en_edges = 0;
      start_gen(mem_unit_pkg::gen_b);
      while (!(done_b && !en_b)) begin
         if (en_b) begin
            if (first_en_edges == 0)
               first_en_edges = edges;
            if (idx < wr_words.size())
               wr_data = wr_words[idx];
            idx++;
         end
         @(negedge clk);
         edges++;
         if (edges > limit) begin
            timed_out("write stream never raised done_b");
            break;
         end
      end
      check_val("write count", wr_words.size(), idx);
   endtask

   task automatic read_stream(input int pause_pct, input int rerun_cycle);
      int k;
      int streak;
      k = 0;
      streak = 0;
      longest_streak = 0;
      got.delete();
      start_gen(mem_unit_pkg::gen_a);
      while (1) begin
         @(negedge clk); // outputs settled since the rising edge
         k++;
         if (rd_valid) begin
            got.push_back(rd_data);
            streak++;
         end else begin
            streak = 0;
         end
         if (streak > longest_streak)
            longest_streak = streak;
         // done stays a single cycle on a rerun, so look past it
         if (done_a && !pause && (rerun_cycle == 0 || k > rerun_cycle + 1))
            break;
         if (k > 5000) begin
            timed_out("read stream never raised done_a");
            break;
         end
         pause = (pause_pct > 0) && ((($random(seed) & 32'h7fff_ffff) % 100) < pause_pct);
         run = (k == rerun_cycle - 1); // high through the final cycle
         gen_mask = 2'b00;
         gen_mask[mem_unit_pkg::gen_a] = run;
      end
      pause    = 1'b0;
      run      = 1'b0;
      gen_mask = 2'b00;
   endtask

   task automatic compare_words(input string name);
      check_val("word count", exp_words.size(), got.size());
      for (int i = 0; i < exp_words.size() && i < got.size(); i++)
         check_val(name, exp_words[i], got[i]);
   endtask

   initial begin
      rst       = 1'b1;
      cfg_we    = 1'b0;
      cfg_sel   = 1'b0;
      cfg_field = mem_unit_pkg::f_iterations;
      cfg_data  = '0;
      init      = 1'b0;
      run       = 1'b0;
      gen_mask  = 2'b00;
      pause     = 1'b0;
      wr_data   = '0;
      repeat (10) @(negedge clk);
      rst = 1'b0;

      begin_test();
      @(negedge clk);
      check_val("done_a", 1, 32'(done_a));
      check_val("done_b", 1, 32'(done_b));
      check_val("rd_valid", 0, 32'(rd_valid));
      check_val("en_b", 0, 32'(en_b));
      end_test("reset");

      begin_test();
      wr_words.delete();
      for (int i = 0; i < 16; i++)
         wr_words.push_back($random(seed));
      config_gen(mem_unit_pkg::gen_b, 16, 1, 1, 0, 0, 0, 1);
      write_stream(200);
      config_gen(mem_unit_pkg::gen_a, 16, 1, 1, 0, 0, 0, 1);
      read_stream(0, 0);
      exp_words = wr_words;
      compare_words("rd_data");
      end_test("linear load and readback");

      begin_test();
      wr_words.delete();
      for (int i = 0; i <= addr_mask; i++)
         wr_words.push_back(i);
      config_gen(mem_unit_pkg::gen_b, 256, 4, 4, 0, 0, 0, 1); // whole memory
      write_stream(2000);
      config_gen(mem_unit_pkg::gen_a, 6, 5, 3, 0, 4, 40, -3); // wraps below zero
      read_stream(0, 0);
      exp_words.delete();
      build_expected(4, -3, 40, 3, 6);
      check_val("valid word count", 6 * 3, got.size());
      compare_words("rd_data");
      ref_words = got;
      end_test("two-dimensional pattern");

      begin_test();
      wr_words.delete();
      for (int i = 300; i < 304; i++)
         wr_words.push_back(i);
      config_gen(mem_unit_pkg::gen_b, 4, 1, 1, 5, 300, 0, 1);
      write_stream(200);
      check_val("first en_b edge", 5 + 1, first_en_edges);
      end_test("delay");

      begin_test();
      read_stream(30, 0); // same pattern as the unpaused run
      exp_words = ref_words;
      compare_words("rd_data");
      end_test("pause");

      begin_test();
      config_gen(mem_unit_pkg::gen_a, 3, 3, 3, 0, 50, 1, 2);
      read_stream(0, 9);
      exp_words.delete();
      build_expected(50, 2, 1, 3, 3);
      build_expected(50, 2, 1, 3, 3);
      compare_words("rd_data");
      check_val("rd_valid streak", 18, longest_streak);
      end_test("back-to-back run");

      finish_run();
   end

endmodule

`default_nettype wire

// ==== project.f ====
addrgen_pkg.sv
mem_unit_pkg.sv
addrgen.sv
cfg_regs.sv
dp_mem.sv
mem_unit_top.sv
tb_mem_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mem_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_mem_unit -f project.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '^>>> FAIL$' "$log"; then
   echo "testbench reported a failure, see $log"
   exit 1
fi

exit 0
